/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_loader_tb
FILELIST  ?= mem_loader_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* mem_loader_top.f */
rtl/mem_map_pkg.sv
rtl/loader_pkg.sv
rtl/dual_port_ram.sv
rtl/loader_regs.sv
rtl/mem_controller.sv
rtl/mem_loader_top.sv
verif/tb_clock_gen.sv
verif/mem_loader_chk.sv
verif/mem_loader_tb.sv

/* rtl/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram #(
  parameter type word_t = logic [31:0],
  parameter int  ADDR_W = 8
) (
  input  logic                 clock,
  input  mem_map_pkg::ram_wr_t a_wr,
  input  logic [ADDR_W-1:0]    a_raddr,
  output word_t                a_rdata,
  input  mem_map_pkg::ram_wr_t b_wr,
  input  logic [ADDR_W-1:0]    b_raddr,
  output word_t                b_rdata
);

  localparam int WORD_W = $bits(word_t);

  word_t mem [2**ADDR_W];

  always_ff @(posedge clock) begin
    if (a_wr.en) begin
      mem[a_wr.addr[ADDR_W-1:0]] <= word_t'(a_wr.data[WORD_W-1:0]);
    end
    // port b comes second so it wins on a same-address collision
    if (b_wr.en) begin
      mem[b_wr.addr[ADDR_W-1:0]] <= word_t'(b_wr.data[WORD_W-1:0]);
    end
    a_rdata <= mem[a_raddr]; // registered read
    b_rdata <= mem[b_raddr];
  end

endmodule

/* rtl/loader_pkg.sv */
package loader_pkg;

  // apb side
  localparam int APB_ADDR_W = 16;
  localparam int APB_DATA_W = 32;
  localparam int WORD_LSB   = 2;  // byte address to word index
  localparam int WIN_SEL_LSB = 12; // paddr[15:12] picks the region

  // address map
  localparam logic [APB_ADDR_W-1:0] CMD_OFFSET    = 16'h0000;
  localparam logic [APB_ADDR_W-1:0] STATUS_OFFSET = 16'h0004;
  localparam logic [APB_ADDR_W-1:0] SRC_WIN_BASE  = 16'h1000;
  localparam logic [APB_ADDR_W-1:0] IM_WIN_BASE   = 16'h2000;
  localparam logic [APB_ADDR_W-1:0] DM_WIN_BASE   = 16'h3000;

  // word count, 1 to 256
  localparam int SIZE_W = 9;
  localparam int CMD_W  = 29;

  // command word, bit 28 down to bit 0
  typedef struct packed {
    logic                              op_clear; // 1 zero-fill, 0 copy
    logic                              target;   // 0 im, 1 dm
    logic [mem_map_pkg::SRC_ADDR_W-1:0] src_addr;
    logic [mem_map_pkg::IM_ADDR_W-1:0]  dst_addr;
    logic [SIZE_W-1:0]                 size;
  } loader_cmd_t;

  typedef struct packed {
    logic busy;
    logic done;
  } loader_status_t;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } loader_state_t;

endpackage

/* rtl/loader_regs.sv */
`timescale 1ns/1ps

module loader_regs (
  input  logic                                clock,
  input  logic                                reset,
  // apb slave
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [loader_pkg::APB_ADDR_W-1:0]   paddr,
  input  logic [loader_pkg::APB_DATA_W-1:0]   pwdata,
  output logic [loader_pkg::APB_DATA_W-1:0]   prdata,
  output logic                                pready,
  output logic                                pslverr,
  // engine
  output loader_pkg::loader_cmd_t             cmd,
  output logic                                start,
  input  loader_pkg::loader_status_t          status,
  // memory windows, port a
  output mem_map_pkg::ram_wr_t                src_wr,
  output logic [mem_map_pkg::SRC_ADDR_W-1:0]  src_raddr,
  input  mem_map_pkg::src_word_t              src_rdata,
  output mem_map_pkg::ram_wr_t                im_wr,
  output logic [mem_map_pkg::IM_ADDR_W-1:0]   im_raddr,
  input  mem_map_pkg::im_word_t               im_rdata,
  output mem_map_pkg::ram_wr_t                dm_wr,
  output logic [mem_map_pkg::DM_ADDR_W-1:0]   dm_raddr,
  input  mem_map_pkg::dm_word_t               dm_rdata
);

  import loader_pkg::*;
  import mem_map_pkg::*;

  logic        access;
  logic        is_cmd;
  logic        is_status;
  logic        is_src;
  logic        is_im;
  logic        is_dm;
  logic        is_win;
  logic        win_read;
  logic        cmd_bad;
  logic        err;
  logic        cmd_wr;
  logic        rd_wait; // window read in its wait state
  loader_cmd_t new_cmd;
  logic [SRC_ADDR_W:0] src_end;
  logic [SIZE_W:0]     dst_end;

  assign access = psel & penable;

  // region decode
  assign is_cmd    = (paddr == CMD_OFFSET);
  assign is_status = (paddr == STATUS_OFFSET);
  assign is_src = (paddr[APB_ADDR_W-1:WIN_SEL_LSB] == SRC_WIN_BASE[APB_ADDR_W-1:WIN_SEL_LSB]);
  assign is_im  = (paddr[APB_ADDR_W-1:WIN_SEL_LSB] == IM_WIN_BASE[APB_ADDR_W-1:WIN_SEL_LSB]);
  assign is_dm  = (paddr[APB_ADDR_W-1:WIN_SEL_LSB] == DM_WIN_BASE[APB_ADDR_W-1:WIN_SEL_LSB]);
  assign is_win = is_src | is_im | is_dm;

  // command checks, end addresses are one past the last word
  assign new_cmd = loader_cmd_t'(pwdata[CMD_W-1:0]);
  assign src_end = (SRC_ADDR_W+1)'(new_cmd.src_addr) + (SRC_ADDR_W+1)'(new_cmd.size);
  assign dst_end = (SIZE_W+1)'(new_cmd.dst_addr) + (SIZE_W+1)'(new_cmd.size);

  always_comb begin
    cmd_bad = 1'b0;
    if (new_cmd.size == '0) begin
      cmd_bad = 1'b1;
    end
    if (src_end > SRC_DEPTH) begin
      cmd_bad = 1'b1;
    end
    if (dst_end > (new_cmd.target ? DM_DEPTH : IM_DEPTH)) begin
      cmd_bad = 1'b1;
    end
  end

  assign err = (status.busy & (is_cmd | is_win)) | (is_cmd & pwrite & cmd_bad);

  // window reads hold pready low for one cycle
  assign win_read = access & ~pwrite & is_win;
  assign pready   = access & (~win_read | err | rd_wait);
  assign pslverr  = pready & err;

  assign cmd_wr = access & pwrite & is_cmd & ~err;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_wait <= 1'b0;
      start   <= 1'b0;
    end else begin
      rd_wait <= win_read & ~err & ~rd_wait;
      start   <= cmd_wr; // one-cycle pulse, cmd lands on the same edge
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_wr) begin
      cmd <= new_cmd;
    end
  end

  // port a read addresses follow paddr
  assign src_raddr = paddr[WORD_LSB +: SRC_ADDR_W];
  assign im_raddr  = paddr[WORD_LSB +: IM_ADDR_W];
  assign dm_raddr  = paddr[WORD_LSB +: DM_ADDR_W];

  always_comb begin
    src_wr = '{en:   access & pwrite & is_src & ~err,
               addr: WR_ADDR_W'(src_raddr),
               data: WR_DATA_W'(pwdata)};
    im_wr  = '{en:   access & pwrite & is_im & ~err,
               addr: WR_ADDR_W'(im_raddr),
               data: WR_DATA_W'(pwdata)};
    dm_wr  = '{en:   access & pwrite & is_dm & ~err,
               addr: WR_ADDR_W'(dm_raddr),
               data: WR_DATA_W'(pwdata)};
  end

  // read mux, ram data is valid in the wait cycle
  always_comb begin
    prdata = '0;
    if (is_cmd) begin
      prdata = APB_DATA_W'(cmd);
    end else if (is_status) begin
      prdata = APB_DATA_W'(status);
    end else if (is_src) begin
      prdata = APB_DATA_W'(src_rdata);
    end else if (is_im) begin
      prdata = APB_DATA_W'(im_rdata);
    end else if (is_dm) begin
      prdata = APB_DATA_W'(dm_rdata); // upper half reads zero
    end
  end

endmodule

/* rtl/mem_controller.sv */
`timescale 1ns/1ps

module mem_controller (
  input  logic                               clock,
  input  logic                               reset,
  input  loader_pkg::loader_cmd_t            cmd,
  input  logic                               start,
  output loader_pkg::loader_status_t         status,
  output logic [mem_map_pkg::SRC_ADDR_W-1:0] src_raddr,
  input  mem_map_pkg::src_word_t             src_rdata,
  output mem_map_pkg::ram_wr_t               im_wr,
  output mem_map_pkg::ram_wr_t               dm_wr
);

  import loader_pkg::*;
  import mem_map_pkg::*;

  loader_state_t          state;
  logic [SIZE_W-1:0]      rd_cnt;   // reads still to issue
  logic [SRC_ADDR_W-1:0]  rd_ptr;
  logic [IM_ADDR_W-1:0]   wr_ptr;
  logic                   rd_valid; // source word returns this cycle
  logic                   rd_issue;
  logic                   last_wr;
  logic                   done;
  logic                   job_clear;
  logic                   job_target;
  logic [WR_DATA_W-1:0]   wr_data;
  logic                   accept;

  assign accept   = (state == ST_IDLE) & start;
  assign rd_issue = (state == ST_RUN) & (rd_cnt != '0);
  assign last_wr  = rd_valid & (rd_cnt == '0);

  assign src_raddr = rd_ptr;

  // control: idle/run fsm plus read stage valid
  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= ST_IDLE;
      rd_cnt   <= '0;
      rd_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      rd_valid <= rd_issue;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state  <= ST_RUN;
            rd_cnt <= cmd.size;
            done   <= 1'b0;
          end
        end
        ST_RUN: begin
          if (rd_issue) begin
            rd_cnt <= rd_cnt - 1'b1;
          end
          if (last_wr) begin
            state <= ST_IDLE;
            done  <= 1'b1; // held until the next start
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address counters and the latched job kind
  always_ff @(posedge clock) begin
    if (accept) begin
      rd_ptr     <= cmd.src_addr;
      wr_ptr     <= cmd.dst_addr;
      job_clear  <= cmd.op_clear;
      job_target <= cmd.target;
    end else begin
      if (rd_issue) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (rd_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // write stage
  assign wr_data = job_clear ? '0 : WR_DATA_W'(src_rdata);

  always_comb begin
    im_wr = '{en:   rd_valid & ~job_target,
              addr: WR_ADDR_W'(wr_ptr),
              data: wr_data};
    dm_wr = '{en:   rd_valid & job_target,
              addr: WR_ADDR_W'(wr_ptr),
              data: wr_data};
  end

  assign status = '{busy: (state == ST_RUN), done: done};

endmodule

/* rtl/mem_loader_top.sv */
`timescale 1ns/1ps

module mem_loader_top (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [loader_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [loader_pkg::APB_DATA_W-1:0] pwdata,
  output logic [loader_pkg::APB_DATA_W-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr
);

  import loader_pkg::*;
  import mem_map_pkg::*;

  loader_cmd_t    cmd;
  logic           start;
  loader_status_t status;

  // host side, port a
  ram_wr_t                src_wr_a;
  ram_wr_t                im_wr_a;
  ram_wr_t                dm_wr_a;
  logic [SRC_ADDR_W-1:0]  src_raddr_a;
  logic [IM_ADDR_W-1:0]   im_raddr_a;
  logic [DM_ADDR_W-1:0]   dm_raddr_a;
  src_word_t              src_rdata_a;
  im_word_t               im_rdata_a;
  dm_word_t               dm_rdata_a;

  // engine side, port b
  logic [SRC_ADDR_W-1:0]  src_raddr_b;
  src_word_t              src_rdata_b;
  ram_wr_t                im_wr_b;
  ram_wr_t                dm_wr_b;

  loader_regs u_regs (
    .clock     (clock),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cmd       (cmd),
    .start     (start),
    .status    (status),
    .src_wr    (src_wr_a),
    .src_raddr (src_raddr_a),
    .src_rdata (src_rdata_a),
    .im_wr     (im_wr_a),
    .im_raddr  (im_raddr_a),
    .im_rdata  (im_rdata_a),
    .dm_wr     (dm_wr_a),
    .dm_raddr  (dm_raddr_a),
    .dm_rdata  (dm_rdata_a)
  );

  mem_controller u_ctrl (
    .clock     (clock),
    .reset     (reset),
    .cmd       (cmd),
    .start     (start),
    .status    (status),
    .src_raddr (src_raddr_b),
    .src_rdata (src_rdata_b),
    .im_wr     (im_wr_b),
    .dm_wr     (dm_wr_b)
  );

  // engine only reads the source memory
  dual_port_ram #(.word_t(src_word_t), .ADDR_W(SRC_ADDR_W)) u_src_mem (
    .clock   (clock),
    .a_wr    (src_wr_a),
    .a_raddr (src_raddr_a),
    .a_rdata (src_rdata_a),
    .b_wr    ('0),
    .b_raddr (src_raddr_b),
    .b_rdata (src_rdata_b)
  );

  // destinations, engine only writes
  dual_port_ram #(.word_t(im_word_t), .ADDR_W(IM_ADDR_W)) u_im_mem (
    .clock   (clock),
    .a_wr    (im_wr_a),
    .a_raddr (im_raddr_a),
    .a_rdata (im_rdata_a),
    .b_wr    (im_wr_b),
    .b_raddr ('0),
    .b_rdata ()
  );

  dual_port_ram #(.word_t(dm_word_t), .ADDR_W(DM_ADDR_W)) u_dm_mem (
    .clock   (clock),
    .a_wr    (dm_wr_a),
    .a_raddr (dm_raddr_a),
    .a_rdata (dm_rdata_a),
    .b_wr    (dm_wr_b),
    .b_raddr ('0),
    .b_rdata ()
  );

endmodule

/* rtl/mem_map_pkg.sv */
package mem_map_pkg;

  // address widths of the three memories
  localparam int SRC_ADDR_W = 10;
  localparam int IM_ADDR_W  = 8;
  localparam int DM_ADDR_W  = 8;

  localparam int SRC_DEPTH = 1 << SRC_ADDR_W;
  localparam int IM_DEPTH  = 1 << IM_ADDR_W;
  localparam int DM_DEPTH  = 1 << DM_ADDR_W;

  // word widths
  localparam int SRC_W = 32;
  localparam int IM_W  = 32;
  localparam int DM_W  = 16;

  // write port covers the widest memory, narrower ones use the low bits
  localparam int WR_ADDR_W = SRC_ADDR_W;
  localparam int WR_DATA_W = 32;

  typedef logic [SRC_W-1:0] src_word_t;
  typedef logic [IM_W-1:0]  im_word_t;
  typedef logic [DM_W-1:0]  dm_word_t;

  // one write port of a memory
  typedef struct packed {
    logic                 en;
    logic [WR_ADDR_W-1:0] addr;
    logic [WR_DATA_W-1:0] data; // dm keeps bits 15:0 only
  } ram_wr_t;

endpackage

/* verif/mem_loader_chk.sv */
`timescale 1ns/1ps

module mem_loader_chk (
  input logic                       clock,
  input logic                       reset,
  input logic                       start,
  input loader_pkg::loader_cmd_t    cmd,
  input loader_pkg::loader_status_t status,
  input mem_map_pkg::ram_wr_t       im_wr,
  input mem_map_pkg::ram_wr_t       dm_wr
);

  import loader_pkg::*;

  logic       start_seen; // start arrived since the last done
  logic       timing;
  logic [9:0] since_start;
  logic [9:0] job_len;    // size plus 2

  always_ff @(posedge clock) begin
    if (reset) begin
      start_seen  <= 1'b0;
      timing      <= 1'b0;
      since_start <= '0;
      job_len     <= '0;
    end else begin
      if (start) begin
        start_seen  <= 1'b1;
        timing      <= 1'b1;
        since_start <= 10'd1;
        job_len     <= 10'(cmd.size) + 10'd2;
      end else begin
        if (status.done) begin
          start_seen <= 1'b0;
        end
        if (timing) begin
          since_start <= since_start + 10'd1;
          if (since_start == job_len) begin
            timing <= 1'b0;
          end
        end
      end
    end
  end

  // exactly one destination written, and it is the one the command register names
  a_one_target: assert property (@(posedge clock) disable iff (reset)
    (im_wr.en || dm_wr.en) |-> (im_wr.en != dm_wr.en) && (dm_wr.en == cmd.target))
    else $error("destination write enables do not match the command target");

  a_write_when_busy: assert property (@(posedge clock) disable iff (reset)
    !status.busy |-> !(im_wr.en || dm_wr.en))
    else $error("destination write while the engine is idle");

  a_done_after_start: assert property (@(posedge clock) disable iff (reset)
    $rose(status.done) |-> start_seen)
    else $error("done rose with no start before it");

  a_busy_length: assert property (@(posedge clock) disable iff (reset)
    (timing && since_start == job_len) |-> $fell(status.busy))
    else $error("busy did not fall size plus 2 cycles after start");

endmodule

/* verif/mem_loader_tb.sv */
`timescale 1ns/1ps

module mem_loader_tb;

  import loader_pkg::*;
  import mem_map_pkg::*;

  localparam int N_JOBS      = 10;
  localparam int N_SRC_READS = 64;
  localparam int N_CMDS      = N_JOBS + 7;
  localparam int N_ACCESS    = SRC_DEPTH + 3 * (IM_DEPTH + DM_DEPTH) + N_SRC_READS
                               + (N_JOBS + 2) * (IM_DEPTH + 2) + 64;
  localparam int CYCLE_LIMIT = N_CMDS * (256 + 20) + N_ACCESS * 4 + 2000;
  localparam int POLL_LIMIT  = 100; // status reads per job

  logic        clock;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // reference model of the three memories
  logic [31:0] src_model [SRC_DEPTH];
  logic [31:0] im_model [IM_DEPTH];
  logic [15:0] dm_model [DM_DEPTH];

  logic [31:0] rng;
  int          n_errors;
  int          n_checks;
  int          cycles = 0;

  tb_clock_gen u_clk (.clock(clock), .reset(reset));

  mem_loader_top UUT (
    .clock   (clock),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  bind mem_controller mem_loader_chk u_chk (
    .clock  (clock),
    .reset  (reset),
    .start  (start),
    .cmd    (cmd),
    .status (status),
    .im_wr  (im_wr),
    .dm_wr  (dm_wr)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] win_addr(input logic [15:0] base, input int idx);
    return base + 16'(idx * 4);
  endfunction

  // op_clear, target, src, dst, size from bit 28 down
  function automatic logic [31:0] make_cmd(input logic clr, input logic tgt,
                                           input int src, input int dst, input int size);
    return {3'b000, clr, tgt, src[9:0], dst[7:0], size[8:0]};
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("Error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  // one apb transfer with outputs sampled mid-cycle
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err, output int waits);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clock);
    penable <= 1'b1;
    waits = 0;
    @(negedge clock);
    while (!pready) begin
      waits++;
      @(negedge clock);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock); // access completes here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                            input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_xfer(1'b1, addr, data, rdata, err, waits);
    check(32'(err), 32'(exp_err), $sformatf("pslverr on write to %h", addr));
    check(waits, 0, "wait states on write");
  endtask

  task automatic read_window(input logic [15:0] addr, output logic [31:0] data);
    logic err;
    int   waits;
    apb_xfer(1'b0, addr, 32'h0, data, err, waits);
    check(32'(err), 32'h0, $sformatf("pslverr on read of %h", addr));
    check(waits, 1, "one wait state on window read");
  endtask

  task automatic read_status(output logic [1:0] st);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_xfer(1'b0, STATUS_OFFSET, 32'h0, rdata, err, waits);
    check(32'(err), 32'h0, "pslverr on status read");
    check(waits, 0, "wait states on status read");
    check(32'(rdata[31:2]), 32'h0, "upper status bits");
    st = rdata[1:0]; // busy, done
  endtask

  task automatic model_job(input logic clr, input logic tgt,
                           input int src, input int dst, input int size);
    for (int i = 0; i < size; i++) begin
      if (tgt) begin
        dm_model[dst+i] = clr ? 16'h0 : src_model[src+i][15:0];
      end else begin
        im_model[dst+i] = clr ? 32'h0 : src_model[src+i];
      end
    end
  endtask

  task automatic check_dest(input logic tgt);
    logic [31:0] rdata;
    for (int i = 0; i < IM_DEPTH; i++) begin
      if (tgt) begin
        read_window(win_addr(DM_WIN_BASE, i), rdata);
        check(rdata, {16'h0, dm_model[i]}, $sformatf("dm word %0d", i));
      end else begin
        read_window(win_addr(IM_WIN_BASE, i), rdata);
        check(rdata, im_model[i], $sformatf("im word %0d", i));
      end
    end
  endtask

  task automatic wait_done();
    logic [1:0] st;
    int         polls;
    polls = 0;
    read_status(st);
    while (st != 2'b01 && polls < POLL_LIMIT) begin
      check(32'(st), 32'h2, "status while the job runs");
      polls++;
      read_status(st);
    end
    if (st != 2'b01) begin
      n_errors++;
      $display("engine did not report done within %0d status reads", POLL_LIMIT);
    end
    check(32'(st), 32'h1, "status after job");
  endtask

  task automatic run_job(input logic clr, input logic tgt,
                         input int src, input int dst, input int size);
    write_word(CMD_OFFSET, make_cmd(clr, tgt, src, dst, size), 1'b0);
    model_job(clr, tgt, src, dst, size);
    wait_done();
    check_dest(tgt);
  endtask

  task automatic random_job(input logic [1:0] kind);
    int size;
    int src;
    int dst;
    rng = xorshift32(rng);
    size = int'(rng[7:0]) + 1;
    rng = xorshift32(rng);
    src = int'(rng % 32'(SRC_DEPTH - size + 1));
    rng = xorshift32(rng);
    dst = int'(rng % 32'(IM_DEPTH - size + 1));
    run_job(kind[1], kind[0], src, dst, size); // kind 0 im, 1 dm, 2 and 3 clear
  endtask

  // accesses while a long copy runs must all be refused
  task automatic busy_job();
    logic [31:0] rdata;
    logic        err;
    int          waits;
    logic [1:0]  st;
    int          src;
    int          dst;
    rng = xorshift32(rng);
    src = int'(rng % 32'(SRC_DEPTH - 199));
    rng = xorshift32(rng);
    dst = int'(rng % 32'(IM_DEPTH - 199));
    write_word(CMD_OFFSET, make_cmd(1'b0, 1'b0, src, dst, 200), 1'b0);
    model_job(1'b0, 1'b0, src, dst, 200);
    write_word(CMD_OFFSET, make_cmd(1'b1, 1'b0, 0, 0, 16), 1'b1);
    write_word(win_addr(IM_WIN_BASE, dst), 32'hdead_beef, 1'b1);
    write_word(win_addr(SRC_WIN_BASE, src + 150), ~src_model[src+150], 1'b1);
    write_word(win_addr(DM_WIN_BASE, 3), 32'h0000_1234, 1'b1);
    apb_xfer(1'b0, win_addr(IM_WIN_BASE, dst), 32'h0, rdata, err, waits);
    check(32'(err), 32'h1, "pslverr on window read while busy");
    read_status(st);
    check(32'(st), 32'h2, "status while busy");
    wait_done();
    check_dest(1'b0);
    read_window(win_addr(SRC_WIN_BASE, src + 150), rdata);
    check(rdata, src_model[src+150], "source word after refused write");
  endtask

  task automatic bad_commands();
    logic [1:0] after;
    write_word(CMD_OFFSET, make_cmd(1'b0, 1'b0, 0, 0, 0), 1'b1);    // size zero
    write_word(CMD_OFFSET, make_cmd(1'b0, 1'b1, 1000, 0, 50), 1'b1); // source overrun
    write_word(CMD_OFFSET, make_cmd(1'b0, 1'b0, 0, 250, 10), 1'b1);  // im overrun
    write_word(CMD_OFFSET, make_cmd(1'b1, 1'b1, 0, 200, 57), 1'b1);  // dm overrun
    read_status(after);
    check(32'(after), 32'h1, "status after refused commands"); // last accepted job done
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] rdata;
    int          idx;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    n_errors = 0;
    n_checks = 0;
    rng      = 32'h842a1540;
    wait (reset == 1'b0);

    // source gets random words, destinations an address pattern
    for (int i = 0; i < SRC_DEPTH; i++) begin
      rng = xorshift32(rng);
      src_model[i] = rng;
      write_word(win_addr(SRC_WIN_BASE, i), rng, 1'b0);
    end
    for (int i = 0; i < IM_DEPTH; i++) begin
      im_model[i] = {8'hc3, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
      write_word(win_addr(IM_WIN_BASE, i), im_model[i], 1'b0);
    end
    for (int i = 0; i < DM_DEPTH; i++) begin
      dm_model[i] = {~8'(i), 8'(i)};
      write_word(win_addr(DM_WIN_BASE, i), {16'hffff, dm_model[i]}, 1'b0); // top half dropped
    end

    for (int i = 0; i < N_SRC_READS; i++) begin
      rng = xorshift32(rng);
      idx = int'(rng % 32'(SRC_DEPTH));
      read_window(win_addr(SRC_WIN_BASE, idx), rdata);
      check(rdata, src_model[idx], $sformatf("source word %0d", idx));
    end
    check_dest(1'b0);
    check_dest(1'b1);

    for (int j = 0; j < N_JOBS; j++) begin
      rng = xorshift32(rng);
      random_job(j < 4 ? 2'(j) : rng[1:0]);
    end
    run_job(1'b0, 1'b1, SRC_DEPTH - 16, DM_DEPTH - 16, 16); // both ranges end at the top
    busy_job();
    bad_commands();
    check_dest(1'b0);
    check_dest(1'b1);

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int RESET_CYCLES = 4;

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock; // 20 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule
